// ==== common/sm_arith_pkg.sv ====
package sm_arith_pkg;

  localparam int SM_WIDTH = 16;
  localparam int SM_MAG_W = SM_WIDTH - 1;
  localparam logic [SM_MAG_W-1:0] SM_MAG_MAX = 15'd32767;

  // Bit 15 is the sign, bits 14:0 the magnitude.
  typedef logic [SM_WIDTH-1:0] sm_word_t;

  // Negative zero does not count as negative.
  function automatic logic sm_is_neg(input sm_word_t x);
    return x[SM_WIDTH-1] && (x[SM_MAG_W-1:0] != '0);
  endfunction

  function automatic sm_word_t sm_mul(input sm_word_t x, input sm_word_t y);
    logic [2*SM_MAG_W-1:0] prod;
    logic [SM_MAG_W-1:0]   mag;
    logic                  sign;
    prod = x[SM_MAG_W-1:0] * y[SM_MAG_W-1:0];
    mag  = (prod > SM_MAG_MAX) ? SM_MAG_MAX : prod[SM_MAG_W-1:0];
    sign = (mag == '0) ? 1'b0 : (x[SM_WIDTH-1] ^ y[SM_WIDTH-1]);
    return {sign, mag};
  endfunction

  function automatic sm_word_t sm_add(input sm_word_t x, input sm_word_t y);
    logic [SM_MAG_W:0]   sum;
    logic [SM_MAG_W-1:0] xm;
    logic [SM_MAG_W-1:0] ym;
    logic [SM_MAG_W-1:0] mag;
    logic                sign;
    xm = x[SM_MAG_W-1:0];
    ym = y[SM_MAG_W-1:0];
    if (x[SM_WIDTH-1] == y[SM_WIDTH-1]) begin
      sum  = xm + ym;
      mag  = sum[SM_MAG_W] ? SM_MAG_MAX : sum[SM_MAG_W-1:0];
      sign = x[SM_WIDTH-1];
    end else if (xm >= ym) begin
      mag  = xm - ym;
      sign = x[SM_WIDTH-1];
    end else begin
      mag  = ym - xm;
      sign = y[SM_WIDTH-1];
    end
    if (mag == '0) begin
      sign = 1'b0;
    end
    return {sign, mag};
  endfunction

  // True when x is strictly larger than y.
  function automatic logic sm_greater(input sm_word_t x, input sm_word_t y);
    logic x_neg;
    logic y_neg;
    x_neg = sm_is_neg(x);
    y_neg = sm_is_neg(y);
    if (x_neg != y_neg) begin
      return y_neg;
    end
    if (x_neg) begin
      return x[SM_MAG_W-1:0] < y[SM_MAG_W-1:0];
    end
    return x[SM_MAG_W-1:0] > y[SM_MAG_W-1:0];
  endfunction

endpackage

// ==== common/ffnn_weights_pkg.sv ====
package ffnn_weights_pkg;

  import sm_arith_pkg::*;

  localparam int N_IN    = 4;
  localparam int N_L1    = 8;
  localparam int N_L2    = 6;
  localparam int N_L3    = 3;
  localparam int LABEL_W = 2;

  // Three layer registers plus the label register.
  localparam int PIPE_LATENCY = 4;

  // Tables are [neuron][input], values of 32768 and up are negative.
  localparam sm_word_t l1_weights [N_L1][N_IN] = '{
    '{16'd30,    16'd17,    16'd32788, 16'd32801},
    '{16'd32805, 16'd5,     16'd32795, 16'd32797},
    '{16'd32806, 16'd32793, 16'd32791, 16'd32771},
    '{16'd37,    16'd32777, 16'd35,    16'd24},
    '{16'd32794, 16'd32795, 16'd32784, 16'd26},
    '{16'd32791, 16'd32773, 16'd32792, 16'd24},
    '{16'd13,    16'd1,     16'd19,    16'd44},
    '{16'd29,    16'd39,    16'd32809, 16'd32803}
  };

  localparam sm_word_t l1_bias [N_L1] = '{
    16'd14, 16'd0, 16'd0, 16'd32770, 16'd0, 16'd0, 16'd32771, 16'd7
  };

  localparam sm_word_t l2_weights [N_L2][N_L1] = '{
    '{16'd26,    16'd11,    16'd20,    16'd26,
      16'd26,    16'd32790, 16'd16,    16'd35},
    '{16'd32799, 16'd27,    16'd32783, 16'd20,
      16'd32776, 16'd32778, 16'd13,    16'd18},
    '{16'd13,    16'd18,    16'd32786, 16'd11,
      16'd32788, 16'd12,    16'd33,    16'd32792},
    '{16'd8,     16'd4,     16'd32771, 16'd13,
      16'd32792, 16'd9,     16'd10,    16'd32798},
    '{16'd32781, 16'd32787, 16'd32771, 16'd20,
      16'd32784, 16'd32773, 16'd18,    16'd32774},
    '{16'd32788, 16'd32770, 16'd22,    16'd16,
      16'd32776, 16'd32771, 16'd32793, 16'd2}
  };

  localparam sm_word_t l2_bias [N_L2] = '{
    16'd32769, 16'd32784, 16'd32776, 16'd15, 16'd8, 16'd0
  };

  localparam sm_word_t l3_weights [N_L3][N_L2] = '{
    '{16'd17,    16'd32790, 16'd32800, 16'd32797, 16'd32805, 16'd32774},
    '{16'd32794, 16'd32793, 16'd32784, 16'd23,    16'd19,    16'd4},
    '{16'd32775, 16'd25,    16'd15,    16'd32777, 16'd32780, 16'd0}
  };

  localparam sm_word_t l3_bias [N_L3] = '{
    16'd22, 16'd4, 16'd32796
  };

endpackage

// ==== neuron_layer/neuron_layer.sv ====
`timescale 1ns/1ps

module neuron_layer
  import sm_arith_pkg::*;
#(
  parameter int N_INPUTS   = 4,
  parameter int N_NEURONS  = 8,
  parameter bit APPLY_RELU = 1'b1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  sm_word_t                 weights [N_NEURONS][N_INPUTS],
  input  sm_word_t                 bias    [N_NEURONS],
  input  sm_word_t [N_INPUTS-1:0]  act_in,
  output sm_word_t [N_NEURONS-1:0] act_out
);

  sm_word_t [N_NEURONS-1:0] next_act;

  // Dot product plus bias, accumulated in input order.
  always_comb begin
    sm_word_t acc;
    for (int n = 0; n < N_NEURONS; n++) begin
      acc = '0;
      for (int i = 0; i < N_INPUTS; i++) begin
        acc = sm_add(acc, sm_mul(act_in[i], weights[n][i]));
      end
      acc = sm_add(acc, bias[n]);
      if (APPLY_RELU && sm_is_neg(acc)) begin
        acc = '0;
      end
      next_act[n] = acc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      act_out <= '0;
    end else begin
      act_out <= next_act;
    end
  end

  // A ReLU layer never hands a negative value downstream.
  if (APPLY_RELU) begin : g_relu_chk
    for (genvar n = 0; n < N_NEURONS; n++) begin : g_out
      assert property (@(posedge clk) disable iff (!rst_n)
                       rst_n |=> !sm_is_neg(act_out[n]))
        else $error("neuron_layer: output %0d negative after ReLU", n);
    end
  end

endmodule

// ==== verilog/argmax_label.sv ====
`timescale 1ns/1ps

module argmax_label
  import sm_arith_pkg::*;
  import ffnn_weights_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  sm_word_t [N_L3-1:0] scores,
  output logic [LABEL_W-1:0]  label
);

  logic [LABEL_W-1:0] best_idx;

  // Strict compare, so the lowest index wins a tie.
  always_comb begin
    sm_word_t best;
    best     = scores[0];
    best_idx = '0;
    for (int i = 1; i < N_L3; i++) begin
      if (sm_greater(scores[i], best)) begin
        best     = scores[i];
        best_idx = LABEL_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      label <= '0;
    end else begin
      label <= best_idx;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) label <= LABEL_W'(N_L3 - 1))
    else $error("argmax_label: label %0d out of range", label);

endmodule

// ==== verilog/ffnn_top.sv ====
`timescale 1ns/1ps

module ffnn_top
  import sm_arith_pkg::*;
  import ffnn_weights_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  sm_word_t           a,
  input  sm_word_t           b,
  input  sm_word_t           c,
  input  sm_word_t           d,
  output logic [LABEL_W-1:0] result
);

  sm_word_t [N_IN-1:0] features;
  sm_word_t [N_L1-1:0] l1_act;
  sm_word_t [N_L2-1:0] l2_act;
  sm_word_t [N_L3-1:0] l3_score;

  // Feature a sits at index 0.
  assign features = {d, c, b, a};

  neuron_layer #(.N_INPUTS(N_IN), .N_NEURONS(N_L1), .APPLY_RELU(1'b1)) u_layer1 (
    .clk     (clk),
    .rst_n   (rst_n),
    .weights (l1_weights),
    .bias    (l1_bias),
    .act_in  (features),
    .act_out (l1_act)
  );

  neuron_layer #(.N_INPUTS(N_L1), .N_NEURONS(N_L2), .APPLY_RELU(1'b1)) u_layer2 (
    .clk     (clk),
    .rst_n   (rst_n),
    .weights (l2_weights),
    .bias    (l2_bias),
    .act_in  (l1_act),
    .act_out (l2_act)
  );

  // Output layer keeps raw scores.
  neuron_layer #(.N_INPUTS(N_L2), .N_NEURONS(N_L3), .APPLY_RELU(1'b0)) u_layer3 (
    .clk     (clk),
    .rst_n   (rst_n),
    .weights (l3_weights),
    .bias    (l3_bias),
    .act_in  (l2_act),
    .act_out (l3_score)
  );

  argmax_label u_argmax (
    .clk    (clk),
    .rst_n  (rst_n),
    .scores (l3_score),
    .label  (result)
  );

endmodule

// ==== verif/ffnn_model.svh ====
`ifndef FFNN_MODEL_SVH
`define FFNN_MODEL_SVH

localparam int MAG_LIMIT = 32767;

// Signed integer value of a sign-magnitude word.
function automatic int word_value(input sm_word_t w);
  int mag;
  mag = {17'd0, w[SM_WIDTH-2:0]};
  return w[SM_WIDTH-1] ? -mag : mag;
endfunction

// Clamp to what a 15-bit magnitude can hold.
function automatic int clip_value(input int v);
  if (v > MAG_LIMIT) begin
    return MAG_LIMIT;
  end
  if (v < -MAG_LIMIT) begin
    return -MAG_LIMIT;
  end
  return v;
endfunction

// Expected label, every product and partial sum clipped in input order.
function automatic logic [LABEL_W-1:0] predict_label(input sm_word_t fa, input sm_word_t fb,
                                                    input sm_word_t fc, input sm_word_t fd);
  int x  [N_IN];
  int h1 [N_L1];
  int h2 [N_L2];
  int s  [N_L3];
  int acc;
  int best;
  logic [LABEL_W-1:0] idx;
  x[0] = word_value(fa);
  x[1] = word_value(fb);
  x[2] = word_value(fc);
  x[3] = word_value(fd);
  for (int n = 0; n < N_L1; n++) begin
    acc = 0;
    for (int i = 0; i < N_IN; i++) begin
      acc = clip_value(acc + clip_value(x[i] * word_value(l1_weights[n][i])));
    end
    acc = clip_value(acc + word_value(l1_bias[n]));
    h1[n] = (acc < 0) ? 0 : acc;
  end
  for (int n = 0; n < N_L2; n++) begin
    acc = 0;
    for (int i = 0; i < N_L1; i++) begin
      acc = clip_value(acc + clip_value(h1[i] * word_value(l2_weights[n][i])));
    end
    acc = clip_value(acc + word_value(l2_bias[n]));
    h2[n] = (acc < 0) ? 0 : acc;
  end
  for (int n = 0; n < N_L3; n++) begin
    acc = 0;
    for (int i = 0; i < N_L2; i++) begin
      acc = clip_value(acc + clip_value(h2[i] * word_value(l3_weights[n][i])));
    end
    s[n] = clip_value(acc + word_value(l3_bias[n]));
  end
  // First index wins a tie.
  best = s[0];
  idx  = '0;
  for (int i = 1; i < N_L3; i++) begin
    if (s[i] > best) begin
      best = s[i];
      idx  = LABEL_W'(i);
    end
  end
  return idx;
endfunction

`endif

// ==== verif/ffnn_tb.sv ====
`timescale 1ns/1ps

module ffnn_tb
  import sm_arith_pkg::*;
  import ffnn_weights_pkg::*;
();

  // Roughly three times the cycles all tests take.
  localparam int TIMEOUT_CYCLES = 1000;

  logic               clk;
  logic               rst_n;
  sm_word_t           a;
  sm_word_t           b;
  sm_word_t           c;
  sm_word_t           d;
  logic [LABEL_W-1:0] result;

  int cycle_count;
  int seed;

  logic [LABEL_W-1:0] exp_label_q [$];
  int                 exp_due_q [$];
  string              exp_name_q [$];
  logic [LABEL_W-1:0] exp_label;
  string              exp_name;

`include "ffnn_model.svh"

  ffnn_top u_ffnn_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .a      (a),
    .b      (b),
    .c      (c),
    .d      (d),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic sm_word_t encode_word(input int v);
    int mag;
    mag = (v < 0) ? -v : v;
    return {v < 0, mag[SM_WIDTH-2:0]};
  endfunction

  // Magnitude up to 255, either sign, negative zero included.
  function automatic sm_word_t random_word();
    logic [7:0] m8;
    logic       sgn;
    m8  = 8'($random(seed));
    sgn = 1'($random(seed));
    return {sgn, 7'd0, m8};
  endfunction

  // Due cycle counts edges, so the label is read 4 edges after the drive.
  task automatic apply_vector(input string test_name, input sm_word_t va, input sm_word_t vb,
                              input sm_word_t vc, input sm_word_t vd);
    @(posedge clk);
    #5;
    a = va;
    b = vb;
    c = vc;
    d = vd;
    exp_label_q.push_back(predict_label(va, vb, vc, vd));
    exp_due_q.push_back(cycle_count + PIPE_LATENCY);
    exp_name_q.push_back(test_name);
  endtask

  task automatic wait_for_drain();
    while (exp_due_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("ERROR: simulation timed out after %0d cycles", cycle_count));
    end else begin
      #2;
      if (exp_due_q.size() != 0 && exp_due_q[0] == cycle_count) begin
        exp_label = exp_label_q.pop_front();
        exp_name  = exp_name_q.pop_front();
        void'(exp_due_q.pop_front());
        assert (result === exp_label)
          else abort_run($sformatf("MISMATCH test=%s expected=%0d actual=%0d",
                                   exp_name, exp_label, result));
      end
    end
  end

  task automatic test_reset();
    rst_n = 1'b0;
    // Saturated features reach label 1 if the registers do not clear.
    a = 16'h7FFF;
    b = 16'h7FFF;
    c = 16'h7FFF;
    d = 16'h7FFF;
    repeat (4) begin
      @(posedge clk);
      #2;
      assert (result === '0)
        else abort_run($sformatf("MISMATCH test=test_reset expected=0 actual=%0d", result));
    end
    #3;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    assert (result === '0)
      else abort_run($sformatf("MISMATCH test=test_reset expected=0 actual=%0d", result));
  endtask

  task automatic test_zero_features();
    apply_vector("test_zero_features", '0, '0, '0, '0);
    wait_for_drain();
  endtask

  task automatic test_directed_vectors();
    apply_vector("test_directed_vectors", encode_word(1), encode_word(2),
                 encode_word(3), encode_word(4));
    wait_for_drain();
    apply_vector("test_directed_vectors", encode_word(-5), encode_word(7),
                 encode_word(-9), encode_word(2));
    wait_for_drain();
    apply_vector("test_directed_vectors", encode_word(100), encode_word(-50),
                 encode_word(25), encode_word(-10));
    wait_for_drain();
    apply_vector("test_directed_vectors", encode_word(-1), encode_word(-1),
                 encode_word(-1), encode_word(-1));
    wait_for_drain();
    apply_vector("test_directed_vectors", encode_word(300), encode_word(0),
                 encode_word(-300), encode_word(12));
    wait_for_drain();
  endtask

  task automatic test_streaming();
    for (int i = 0; i < 20; i++) begin
      apply_vector("test_streaming", encode_word(i * 13 - 120), encode_word(70 - i * 9),
                   encode_word((i % 5) * 40 - 80), encode_word(i * i - 150));
    end
    wait_for_drain();
  endtask

  task automatic test_saturation();
    apply_vector("test_saturation", 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
    apply_vector("test_saturation", 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF);
    apply_vector("test_saturation", 16'h7FFF, 16'hFFFF, 16'h7FFF, 16'hFFFF);
    apply_vector("test_saturation", 16'h8000, 16'h7FFF, 16'h8000, 16'hFFFF);
    apply_vector("test_saturation", 16'hFFFF, 16'h8000, 16'h7FFF, 16'h8000);
    wait_for_drain();
  endtask

  task automatic test_random();
    sm_word_t va;
    sm_word_t vb;
    sm_word_t vc;
    sm_word_t vd;
    for (int i = 0; i < 200; i++) begin
      va = random_word();
      vb = random_word();
      vc = random_word();
      vd = random_word();
      apply_vector("test_random", va, vb, vc, vd);
    end
    wait_for_drain();
  endtask

  initial begin
    rst_n       = 1'b0;
    a           = '0;
    b           = '0;
    c           = '0;
    d           = '0;
    cycle_count = 0;
    seed        = 50327;
    test_reset();
    test_zero_features();
    test_directed_vectors();
    test_streaming();
    test_saturation();
    test_random();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verif
common/sm_arith_pkg.sv
common/ffnn_weights_pkg.sv
neuron_layer/neuron_layer.sv
verilog/argmax_label.sv
verilog/ffnn_top.sv
verif/ffnn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the ffnn testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module ffnn_tb \
  -Mdir obj_dir -o ffnn_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/ffnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
